// File: lc3b_cfg.svh
`ifndef LC3B_CFG_SVH
`define LC3B_CFG_SVH

// data and address width
`define LC3B_WORD_W 16

// architectural registers R0..R7
`define LC3B_NUM_REGS 8

// first fetch address out of reset
`define LC3B_RESET_PC 16'h0000

`endif

// File: lc3b_pkg.sv
`include "lc3b_cfg.svh"

package lc3b_pkg;

	typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;

	// n in bit 2, z in bit 1, p in bit 0
	typedef logic [2:0] lc3b_nzp;

	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass
	} alu_op;

	typedef enum logic [1:0] {
		fwd_none,
		fwd_mem,
		fwd_wb
	} fwd_sel;

endpackage

// File: lc3b_decode.sv
`timescale 1ns/1ns
`include "lc3b_cfg.svh"

module lc3b_decode (
	input  lc3b_pkg::lc3b_word   id_instr,
	output lc3b_pkg::lc3b_opcode opcode,
	output lc3b_pkg::alu_op      alu_sel,
	output logic                 use_imm,
	output lc3b_pkg::lc3b_word   imm_value,
	output lc3b_pkg::lc3b_word   offset9_value,
	output lc3b_pkg::lc3b_reg    sr1,
	output lc3b_pkg::lc3b_reg    sr2,
	output lc3b_pkg::lc3b_reg    dest,
	output logic                 reads_sr1,
	output logic                 reads_sr2,
	output logic                 reg_write,
	output logic                 mem_rd,
	output logic                 mem_wr,
	output logic                 is_br,
	output logic                 is_jmp,
	output logic                 sets_cc,
	output lc3b_pkg::lc3b_nzp    nzp_mask
);
	import lc3b_pkg::*;

	lc3b_word imm5_sext;
	lc3b_word off6_scaled;

	assign opcode = lc3b_opcode'(id_instr[15:12]);
	assign sr1 = id_instr[8:6];
	assign dest = id_instr[11:9];
	assign nzp_mask = id_instr[11:9];

	assign imm5_sext = {{(`LC3B_WORD_W-5){id_instr[4]}}, id_instr[4:0]};
	// word offsets become byte offsets
	assign off6_scaled = {{(`LC3B_WORD_W-7){id_instr[5]}}, id_instr[5:0], 1'b0};
	assign offset9_value = {{(`LC3B_WORD_W-10){id_instr[8]}}, id_instr[8:0], 1'b0};

	always_comb begin
		alu_sel = alu_pass;
		use_imm = 1'b0;
		imm_value = imm5_sext;
		sr2 = id_instr[2:0];
		reads_sr1 = 1'b0;
		reads_sr2 = 1'b0;
		reg_write = 1'b0;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		is_br = 1'b0;
		is_jmp = 1'b0;
		sets_cc = 1'b0;
		case (opcode)
			op_add, op_and: begin
				alu_sel = (opcode == op_add) ? alu_add : alu_and;
				use_imm = id_instr[5];
				reads_sr1 = 1'b1;
				reads_sr2 = !id_instr[5];
				reg_write = 1'b1;
				sets_cc = 1'b1;
			end
			op_not: begin
				alu_sel = alu_not;
				reads_sr1 = 1'b1;
				reg_write = 1'b1;
				sets_cc = 1'b1;
			end
			op_lea: begin
				reg_write = 1'b1;
				sets_cc = 1'b1;
			end
			op_ldr: begin
				alu_sel = alu_add;
				use_imm = 1'b1;
				imm_value = off6_scaled;
				reads_sr1 = 1'b1;
				reg_write = 1'b1;
				mem_rd = 1'b1;
				sets_cc = 1'b1;
			end
			op_str: begin
				alu_sel = alu_add;
				use_imm = 1'b1;
				imm_value = off6_scaled;
				// store source rides on the second read port
				sr2 = id_instr[11:9];
				reads_sr1 = 1'b1;
				reads_sr2 = 1'b1;
				mem_wr = 1'b1;
			end
			op_br: is_br = 1'b1;
			op_jmp: begin
				reads_sr1 = 1'b1;
				is_jmp = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// File: lc3b_regfile.sv
`timescale 1ns/1ns
`include "lc3b_cfg.svh"

module lc3b_regfile (
	input  logic               clk,
	input  logic               rst,
	input  logic               wr_en,
	input  lc3b_pkg::lc3b_reg  wr_reg,
	input  lc3b_pkg::lc3b_word wr_data,
	input  lc3b_pkg::lc3b_reg  rd_reg_a,
	input  lc3b_pkg::lc3b_reg  rd_reg_b,
	output lc3b_pkg::lc3b_word rd_data_a,
	output lc3b_pkg::lc3b_word rd_data_b
);
	import lc3b_pkg::*;

	lc3b_word regs [`LC3B_NUM_REGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `LC3B_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_reg] <= wr_data;
		end
	end

	// writeback in the same cycle wins over the stored value
	assign rd_data_a = (wr_en && wr_reg == rd_reg_a) ? wr_data : regs[rd_reg_a];
	assign rd_data_b = (wr_en && wr_reg == rd_reg_b) ? wr_data : regs[rd_reg_b];

endmodule

// File: lc3b_fetch.sv
`timescale 1ns/1ns
`include "lc3b_cfg.svh"

module lc3b_fetch (
	input  logic               clk,
	input  logic               rst,
	input  logic               stall,
	input  logic               flush,
	input  logic               redirect,
	input  lc3b_pkg::lc3b_word redirect_pc,
	output lc3b_pkg::lc3b_word ifetch_address,
	input  lc3b_pkg::lc3b_word ifetch_rdata,
	output lc3b_pkg::lc3b_word id_instr,
	output lc3b_pkg::lc3b_word id_pc,
	output logic               id_valid
);
	import lc3b_pkg::*;

	lc3b_word pc;
	lc3b_word pc_plus2;
	lc3b_word pc_next;

	assign pc_plus2 = pc + `LC3B_WORD_W'(2);
	// predict not taken, the memory stage corrects
	assign pc_next = redirect ? redirect_pc : pc_plus2;
	assign ifetch_address = pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `LC3B_RESET_PC;
			id_valid <= 1'b0;
		end else if (!stall) begin
			pc <= pc_next;
			id_valid <= !flush;
		end
	end

	// IF/ID payload
	always_ff @(posedge clk) begin
		if (!stall) begin
			id_instr <= ifetch_rdata;
			id_pc <= pc_plus2;
		end
	end

endmodule

// File: lc3b_hazard.sv
`timescale 1ns/1ns

module lc3b_hazard (
	input  lc3b_pkg::lc3b_reg ex_sr1,
	input  lc3b_pkg::lc3b_reg ex_sr2,
	input  logic              ex_reads_sr1,
	input  logic              ex_reads_sr2,
	input  lc3b_pkg::lc3b_reg mem_dest,
	input  logic              mem_reg_write,
	input  logic              mem_valid,
	input  lc3b_pkg::lc3b_reg wb_dest,
	input  logic              wb_reg_write,
	input  logic              ex_mem_rd,
	input  lc3b_pkg::lc3b_reg ex_dest,
	input  logic              ex_valid,
	input  lc3b_pkg::lc3b_reg id_sr1,
	input  lc3b_pkg::lc3b_reg id_sr2,
	input  logic              id_reads_sr1,
	input  logic              id_reads_sr2,
	input  logic              id_valid,
	input  logic              redirect,
	output lc3b_pkg::fwd_sel  fwd_a,
	output lc3b_pkg::fwd_sel  fwd_b,
	output logic              load_stall,
	output logic              flush
);
	import lc3b_pkg::*;

	logic id_uses_load;

	// youngest producer first
	function automatic fwd_sel select_source(input logic mem_hit, input logic wb_hit);
		fwd_sel sel;
		sel = fwd_none;
		if (mem_hit)
			sel = fwd_mem;
		else if (wb_hit)
			sel = fwd_wb;
		return sel;
	endfunction

	assign fwd_a = select_source(
		ex_reads_sr1 && mem_valid && mem_reg_write && mem_dest == ex_sr1,
		ex_reads_sr1 && wb_reg_write && wb_dest == ex_sr1);
	assign fwd_b = select_source(
		ex_reads_sr2 && mem_valid && mem_reg_write && mem_dest == ex_sr2,
		ex_reads_sr2 && wb_reg_write && wb_dest == ex_sr2);

	assign id_uses_load = (id_reads_sr1 && id_sr1 == ex_dest) ||
		(id_reads_sr2 && id_sr2 == ex_dest);

	// a redirect discards the consumer anyway
	assign load_stall = ex_valid && ex_mem_rd && id_valid && id_uses_load && !redirect;
	assign flush = redirect;

endmodule

// File: lc3b_execute.sv
`timescale 1ns/1ns

module lc3b_execute (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 stall,
	input  logic                 mem_wait,
	input  logic                 load_stall,
	input  logic                 flush,
	input  lc3b_pkg::lc3b_opcode id_opcode,
	input  lc3b_pkg::alu_op      id_alu_sel,
	input  logic                 id_use_imm,
	input  lc3b_pkg::lc3b_word   id_imm_value,
	input  lc3b_pkg::lc3b_word   id_offset9_value,
	input  lc3b_pkg::lc3b_reg    id_sr1,
	input  lc3b_pkg::lc3b_reg    id_sr2,
	input  lc3b_pkg::lc3b_reg    id_dest,
	input  logic                 id_reads_sr1,
	input  logic                 id_reads_sr2,
	input  logic                 id_reg_write,
	input  logic                 id_mem_rd,
	input  logic                 id_mem_wr,
	input  logic                 id_is_br,
	input  logic                 id_is_jmp,
	input  logic                 id_sets_cc,
	input  lc3b_pkg::lc3b_nzp    id_nzp_mask,
	input  lc3b_pkg::lc3b_word   id_pc,
	input  logic                 id_valid,
	input  lc3b_pkg::lc3b_word   rd_data_a,
	input  lc3b_pkg::lc3b_word   rd_data_b,
	input  lc3b_pkg::fwd_sel     fwd_a,
	input  lc3b_pkg::fwd_sel     fwd_b,
	input  lc3b_pkg::lc3b_word   mem_fwd_value,
	input  lc3b_pkg::lc3b_word   wb_fwd_value,
	output lc3b_pkg::lc3b_reg    ex_sr1,
	output lc3b_pkg::lc3b_reg    ex_sr2,
	output logic                 ex_reads_sr1,
	output logic                 ex_reads_sr2,
	output logic                 ex_mem_rd,
	output lc3b_pkg::lc3b_reg    ex_dest,
	output logic                 ex_valid,
	output logic                 mem_stage_valid,
	output lc3b_pkg::lc3b_word   mem_result,
	output lc3b_pkg::lc3b_word   mem_store_data,
	output lc3b_pkg::lc3b_word   mem_target,
	output lc3b_pkg::lc3b_reg    mem_dest,
	output logic                 mem_reg_write,
	output logic                 mem_rd,
	output logic                 mem_wr,
	output logic                 mem_is_br,
	output logic                 mem_is_jmp,
	output logic                 mem_sets_cc,
	output lc3b_pkg::lc3b_nzp    mem_nzp_mask
);
	import lc3b_pkg::*;

	lc3b_opcode ex_opcode;
	alu_op ex_alu_sel;
	logic ex_use_imm;
	lc3b_word ex_imm;
	lc3b_word ex_off9;
	logic ex_reg_write;
	logic ex_mem_wr;
	logic ex_is_br;
	logic ex_is_jmp;
	logic ex_sets_cc;
	lc3b_nzp ex_nzp_mask;
	lc3b_word ex_pc;
	lc3b_word ex_a;
	lc3b_word ex_b;
	lc3b_word op_a;
	lc3b_word op_b;
	lc3b_word alu_b;
	lc3b_word alu_out;
	lc3b_word pc_target;

	function automatic lc3b_word pick_operand(input fwd_sel sel, input lc3b_word reg_value,
		input lc3b_word mem_value, input lc3b_word wb_value);
		lc3b_word value;
		case (sel)
			fwd_mem: value = mem_value;
			fwd_wb:  value = wb_value;
			default: value = reg_value;
		endcase
		return value;
	endfunction

	// a load-use stall or a flush leaves a bubble in ID/EX
	always_ff @(posedge clk) begin
		if (rst)
			ex_valid <= 1'b0;
		else if (!mem_wait)
			ex_valid <= id_valid && !load_stall && !flush;
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			ex_opcode <= id_opcode;
			ex_alu_sel <= id_alu_sel;
			ex_use_imm <= id_use_imm;
			ex_imm <= id_imm_value;
			ex_off9 <= id_offset9_value;
			ex_sr1 <= id_sr1;
			ex_sr2 <= id_sr2;
			ex_dest <= id_dest;
			ex_reads_sr1 <= id_reads_sr1;
			ex_reads_sr2 <= id_reads_sr2;
			ex_reg_write <= id_reg_write;
			ex_mem_rd <= id_mem_rd;
			ex_mem_wr <= id_mem_wr;
			ex_is_br <= id_is_br;
			ex_is_jmp <= id_is_jmp;
			ex_sets_cc <= id_sets_cc;
			ex_nzp_mask <= id_nzp_mask;
			ex_pc <= id_pc;
			ex_a <= rd_data_a;
			ex_b <= rd_data_b;
		end
	end

	assign op_a = pick_operand(fwd_a, ex_a, mem_fwd_value, wb_fwd_value);
	assign op_b = pick_operand(fwd_b, ex_b, mem_fwd_value, wb_fwd_value);
	assign alu_b = ex_use_imm ? ex_imm : op_b;

	always_comb begin
		case (ex_alu_sel)
			alu_add: alu_out = op_a + alu_b;
			alu_and: alu_out = op_a & alu_b;
			alu_not: alu_out = ~op_a;
			default: alu_out = op_a;
		endcase
	end

	// ex_pc already holds pc+2
	assign pc_target = ex_pc + ex_off9;

	// EX/MEM
	always_ff @(posedge clk) begin
		if (rst)
			mem_stage_valid <= 1'b0;
		else if (!mem_wait)
			mem_stage_valid <= ex_valid && !flush;
	end

	always_ff @(posedge clk) begin
		if (!mem_wait) begin
			mem_result <= (ex_opcode == op_lea) ? pc_target : alu_out;
			mem_store_data <= op_b;
			mem_target <= ex_is_jmp ? op_a : pc_target;
			mem_dest <= ex_dest;
			mem_reg_write <= ex_reg_write;
			mem_rd <= ex_mem_rd;
			mem_wr <= ex_mem_wr;
			mem_is_br <= ex_is_br;
			mem_is_jmp <= ex_is_jmp;
			mem_sets_cc <= ex_sets_cc;
			mem_nzp_mask <= ex_nzp_mask;
		end
	end

endmodule

// File: lc3b_memstage.sv
`timescale 1ns/1ns

module lc3b_memstage (
	input  logic               clk,
	input  logic               rst,
	input  logic               mem_stage_valid,
	input  lc3b_pkg::lc3b_word mem_result,
	input  lc3b_pkg::lc3b_word mem_store_data,
	input  lc3b_pkg::lc3b_word mem_target,
	input  lc3b_pkg::lc3b_reg  mem_dest,
	input  logic               mem_reg_write,
	input  logic               mem_rd,
	input  logic               mem_wr,
	input  logic               mem_is_br,
	input  logic               mem_is_jmp,
	input  logic               mem_sets_cc,
	input  lc3b_pkg::lc3b_nzp  mem_nzp_mask,
	input  lc3b_pkg::lc3b_word mem_rdata,
	input  logic               mem_resp,
	output logic               mem_read,
	output logic               mem_write,
	output lc3b_pkg::lc3b_word mem_address,
	output lc3b_pkg::lc3b_word mem_wdata,
	output logic               mem_wait,
	output logic               redirect,
	output lc3b_pkg::lc3b_word redirect_pc,
	output lc3b_pkg::lc3b_word mem_fwd_value,
	output lc3b_pkg::lc3b_reg  wb_dest,
	output logic               wb_reg_write,
	output lc3b_pkg::lc3b_word wb_data
);
	import lc3b_pkg::*;

	lc3b_nzp cc;
	lc3b_nzp cc_next;
	logic br_taken;

	// EX/MEM holds while waiting, so these stay stable until mem_resp
	assign mem_read = mem_stage_valid && mem_rd;
	assign mem_write = mem_stage_valid && mem_wr;
	assign mem_address = mem_result;
	assign mem_wdata = mem_store_data;
	assign mem_wait = (mem_read || mem_write) && !mem_resp;

	assign mem_fwd_value = mem_rd ? mem_rdata : mem_result;

	assign cc_next[2] = mem_fwd_value[$bits(lc3b_word)-1];
	assign cc_next[1] = (mem_fwd_value == '0);
	assign cc_next[0] = !cc_next[2] && !cc_next[1];

	always_ff @(posedge clk) begin
		if (rst)
			cc <= 3'b010;
		else if (mem_stage_valid && mem_sets_cc && !mem_wait)
			cc <= cc_next;
	end

	assign br_taken = mem_is_br && |(mem_nzp_mask & cc);
	assign redirect = mem_stage_valid && (br_taken || mem_is_jmp);
	assign redirect_pc = mem_target;

	// MEM/WB
	always_ff @(posedge clk) begin
		if (rst)
			wb_reg_write <= 1'b0;
		else if (!mem_wait)
			wb_reg_write <= mem_stage_valid && mem_reg_write;
	end

	always_ff @(posedge clk) begin
		if (!mem_wait) begin
			wb_dest <= mem_dest;
			wb_data <= mem_fwd_value;
		end
	end

endmodule

// File: lc3b_core.sv
`timescale 1ns/1ns

module lc3b_core (
	input  logic               clk,
	input  logic               rst,
	output lc3b_pkg::lc3b_word ifetch_address,
	input  lc3b_pkg::lc3b_word ifetch_rdata,
	output logic               mem_read,
	output logic               mem_write,
	output lc3b_pkg::lc3b_word mem_address,
	output lc3b_pkg::lc3b_word mem_wdata,
	input  lc3b_pkg::lc3b_word mem_rdata,
	input  logic               mem_resp
);
	import lc3b_pkg::*;

	logic stall;
	logic flush;
	logic load_stall;
	logic mem_wait;
	logic redirect;
	lc3b_word redirect_pc;

	lc3b_word id_instr;
	lc3b_word id_pc;
	logic id_valid;
	lc3b_opcode id_opcode;
	alu_op id_alu_sel;
	logic id_use_imm;
	lc3b_word id_imm_value;
	lc3b_word id_offset9_value;
	lc3b_reg id_sr1;
	lc3b_reg id_sr2;
	lc3b_reg id_dest;
	logic id_reads_sr1;
	logic id_reads_sr2;
	logic id_reg_write;
	logic id_mem_rd;
	logic id_mem_wr;
	logic id_is_br;
	logic id_is_jmp;
	logic id_sets_cc;
	lc3b_nzp id_nzp_mask;
	lc3b_word rd_data_a;
	lc3b_word rd_data_b;

	lc3b_reg ex_sr1;
	lc3b_reg ex_sr2;
	logic ex_reads_sr1;
	logic ex_reads_sr2;
	logic ex_mem_rd;
	lc3b_reg ex_dest;
	logic ex_valid;
	fwd_sel fwd_a;
	fwd_sel fwd_b;

	logic mem_stage_valid;
	lc3b_word mem_result;
	lc3b_word mem_store_data;
	lc3b_word mem_target;
	lc3b_reg mem_dest;
	logic mem_reg_write;
	logic mem_rd;
	logic mem_wr;
	logic mem_is_br;
	logic mem_is_jmp;
	logic mem_sets_cc;
	lc3b_nzp mem_nzp_mask;
	lc3b_word mem_fwd_value;

	lc3b_reg wb_dest;
	logic wb_reg_write;
	lc3b_word wb_data;

	// front end holds on a data wait or a load-use hazard
	assign stall = mem_wait || load_stall;

	lc3b_fetch fetch_i (
		.clk,
		.rst,
		.stall,
		.flush,
		.redirect,
		.redirect_pc,
		.ifetch_address,
		.ifetch_rdata,
		.id_instr,
		.id_pc,
		.id_valid
	);

	lc3b_decode decode_i (
		.id_instr,
		.opcode(id_opcode),
		.alu_sel(id_alu_sel),
		.use_imm(id_use_imm),
		.imm_value(id_imm_value),
		.offset9_value(id_offset9_value),
		.sr1(id_sr1),
		.sr2(id_sr2),
		.dest(id_dest),
		.reads_sr1(id_reads_sr1),
		.reads_sr2(id_reads_sr2),
		.reg_write(id_reg_write),
		.mem_rd(id_mem_rd),
		.mem_wr(id_mem_wr),
		.is_br(id_is_br),
		.is_jmp(id_is_jmp),
		.sets_cc(id_sets_cc),
		.nzp_mask(id_nzp_mask)
	);

	lc3b_regfile regfile_i (
		.clk,
		.rst,
		.wr_en(wb_reg_write),
		.wr_reg(wb_dest),
		.wr_data(wb_data),
		.rd_reg_a(id_sr1),
		.rd_reg_b(id_sr2),
		.rd_data_a,
		.rd_data_b
	);

	lc3b_hazard hazard_i (
		.ex_sr1,
		.ex_sr2,
		.ex_reads_sr1,
		.ex_reads_sr2,
		.mem_dest,
		.mem_reg_write,
		.mem_valid(mem_stage_valid),
		.wb_dest,
		.wb_reg_write,
		.ex_mem_rd,
		.ex_dest,
		.ex_valid,
		.id_sr1,
		.id_sr2,
		.id_reads_sr1,
		.id_reads_sr2,
		.id_valid,
		.redirect,
		.fwd_a,
		.fwd_b,
		.load_stall,
		.flush
	);

	lc3b_execute execute_i (
		.clk,
		.rst,
		.stall,
		.mem_wait,
		.load_stall,
		.flush,
		.id_opcode,
		.id_alu_sel,
		.id_use_imm,
		.id_imm_value,
		.id_offset9_value,
		.id_sr1,
		.id_sr2,
		.id_dest,
		.id_reads_sr1,
		.id_reads_sr2,
		.id_reg_write,
		.id_mem_rd,
		.id_mem_wr,
		.id_is_br,
		.id_is_jmp,
		.id_sets_cc,
		.id_nzp_mask,
		.id_pc,
		.id_valid,
		.rd_data_a,
		.rd_data_b,
		.fwd_a,
		.fwd_b,
		.mem_fwd_value,
		.wb_fwd_value(wb_data),
		.ex_sr1,
		.ex_sr2,
		.ex_reads_sr1,
		.ex_reads_sr2,
		.ex_mem_rd,
		.ex_dest,
		.ex_valid,
		.mem_stage_valid,
		.mem_result,
		.mem_store_data,
		.mem_target,
		.mem_dest,
		.mem_reg_write,
		.mem_rd,
		.mem_wr,
		.mem_is_br,
		.mem_is_jmp,
		.mem_sets_cc,
		.mem_nzp_mask
	);

	lc3b_memstage memstage_i (
		.clk,
		.rst,
		.mem_stage_valid,
		.mem_result,
		.mem_store_data,
		.mem_target,
		.mem_dest,
		.mem_reg_write,
		.mem_rd,
		.mem_wr,
		.mem_is_br,
		.mem_is_jmp,
		.mem_sets_cc,
		.mem_nzp_mask,
		.mem_rdata,
		.mem_resp,
		.mem_read,
		.mem_write,
		.mem_address,
		.mem_wdata,
		.mem_wait,
		.redirect,
		.redirect_pc,
		.mem_fwd_value,
		.wb_dest,
		.wb_reg_write,
		.wb_data
	);

endmodule

// File: tb_lc3b.sv
`timescale 1ns/1ns
`include "lc3b_cfg.svh"

module tb_lc3b;

	localparam logic [3:0] opc_br  = 4'b0000;
	localparam logic [3:0] opc_add = 4'b0001;
	localparam logic [3:0] opc_and = 4'b0101;
	localparam logic [3:0] opc_ldr = 4'b0110;
	localparam logic [3:0] opc_str = 4'b0111;
	localparam logic [3:0] opc_not = 4'b1001;
	localparam logic [3:0] opc_jmp = 4'b1100;
	localparam logic [3:0] opc_lea = 4'b1110;

	// instruction counts, the load-use program runs three times
	localparam int arith_len = 15;
	localparam int load_use_len = 9;
	localparam int branch_len = 28;
	localparam int max_latency = 3;
	localparam int total_len = arith_len + 3 * load_use_len + branch_len;
	localparam int timeout_cycles = total_len * (5 + max_latency) * 4;

	logic clk;
	logic rst;
	logic [15:0] ifetch_address;
	logic [15:0] ifetch_rdata;
	logic mem_read;
	logic mem_write;
	logic [15:0] mem_address;
	logic [15:0] mem_wdata;
	logic [15:0] mem_rdata;
	logic mem_resp;

	logic [15:0] imem [256];
	logic [15:0] dmem [256];
	int prog_len;
	logic [15:0] log_addr [$];
	logic [15:0] log_data [$];
	logic [15:0] exp_addr [$];
	logic [15:0] exp_data [$];

	logic random_delay;
	logic [15:0] lfsr_state;
	logic busy;
	int wait_left;
	logic req_read;
	logic req_write;
	logic [15:0] req_addr;
	logic [15:0] req_wdata;

	int checks;
	int value_errors;
	int other_errors;
	int cycle_count;

	lc3b_core lc3b_core_i (
		.clk,
		.rst,
		.ifetch_address,
		.ifetch_rdata,
		.mem_read,
		.mem_write,
		.mem_address,
		.mem_wdata,
		.mem_rdata,
		.mem_resp
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	assign ifetch_rdata = imem[ifetch_address[8:1]];

	function automatic logic [15:0] reg_form(input logic [3:0] op, input int dr, input int sr1,
		input int sr2);
		return {op, dr[2:0], sr1[2:0], 3'b000, sr2[2:0]};
	endfunction

	function automatic logic [15:0] imm_form(input logic [3:0] op, input int dr, input int sr1,
		input int imm);
		return {op, dr[2:0], sr1[2:0], 1'b1, imm[4:0]};
	endfunction

	function automatic logic [15:0] not_word(input int dr, input int sr);
		return {opc_not, dr[2:0], sr[2:0], 6'b111111};
	endfunction

	function automatic logic [15:0] lea_word(input int dr, input int off9);
		return {opc_lea, dr[2:0], off9[8:0]};
	endfunction

	function automatic logic [15:0] ldst_word(input logic [3:0] op, input int r, input int base,
		input int off6);
		return {op, r[2:0], base[2:0], off6[5:0]};
	endfunction

	function automatic logic [15:0] branch_word(input logic [2:0] nzp, input int off9);
		return {opc_br, nzp, off9[8:0]};
	endfunction

	function automatic logic [15:0] jump_word(input int base);
		return {opc_jmp, 3'b000, base[2:0], 6'b000000};
	endfunction

	function automatic logic [15:0] data_fill(input logic [7:0] index);
		return {~index, index};
	endfunction

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	task draw_bits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = (value << 1) | lfsr_state[0];
		end
	endtask

	task check_value(input string name, input logic [15:0] actual, input logic [15:0] expected);
		checks++;
		if (actual !== expected) begin
			value_errors++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
		end
	endtask

	// data memory, one access at a time with 0 to 3 wait cycles
	always begin
		@(posedge clk);
		#10;
		if (mem_resp)
			mem_resp = 1'b0;
		if (!busy && (mem_read || mem_write)) begin
			busy = 1'b1;
			req_read = mem_read;
			req_write = mem_write;
			req_addr = mem_address;
			req_wdata = mem_wdata;
			wait_left = 0;
			if (random_delay)
				draw_bits(2, wait_left);
		end else if (busy) begin
			check_value("mem_read", mem_read, req_read);
			check_value("mem_write", mem_write, req_write);
			check_value("mem_address", mem_address, req_addr);
			check_value("mem_wdata", mem_wdata, req_wdata);
		end
		if (busy) begin
			if (wait_left == 0) begin
				if (req_write) begin
					dmem[req_addr[8:1]] = req_wdata;
					log_addr.push_back(req_addr);
					log_data.push_back(req_wdata);
				end else begin
					mem_rdata = dmem[req_addr[8:1]];
				end
				mem_resp = 1'b1;
				busy = 1'b0;
			end else begin
				wait_left--;
			end
		end
	end

	task clear_memories();
		for (int i = 0; i < 256; i++) begin
			// unused words decode as never-taken branches
			imem[i] = branch_word(3'b000, i);
			dmem[i] = data_fill(i[7:0]);
		end
		prog_len = 0;
		log_addr.delete();
		log_data.delete();
		exp_addr.delete();
		exp_data.delete();
	endtask

	task emit(input logic [15:0] word);
		imem[prog_len] = word;
		prog_len++;
	endtask

	// three stores that a taken branch or jump must discard
	task emit_skipped_stores(input int src, input int first_off);
		for (int k = 0; k < 3; k++)
			emit(ldst_word(opc_str, src, 0, first_off + k));
	endtask

	task expect_store(input logic [15:0] addr, input logic [15:0] data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task check_reset_outputs();
		check_value("mem_read", mem_read, 16'h0000);
		check_value("mem_write", mem_write, 16'h0000);
		check_value("ifetch_address", ifetch_address, `LC3B_RESET_PC);
	endtask

	// the last instruction of every program branches to itself
	task run_program();
		logic [15:0] loop_pc;
		int arrivals;
		logic was_at_loop;
		loop_pc = 16'(2 * (prog_len - 1));
		rst = 1'b1;
		repeat (3) begin
			@(posedge clk);
			#10;
			check_reset_outputs();
		end
		rst = 1'b0;
		check_reset_outputs();
		arrivals = 0;
		was_at_loop = 1'b0;
		while (arrivals < 4) begin
			@(posedge clk);
			#10;
			if (ifetch_address == loop_pc && !was_at_loop)
				arrivals++;
			was_at_loop = (ifetch_address == loop_pc);
		end
	endtask

	task compare_store_log(input string test_name);
		int common;
		common = (log_addr.size() < exp_addr.size()) ? log_addr.size() : exp_addr.size();
		for (int i = 0; i < common; i++) begin
			check_value("mem_address of store", log_addr[i], exp_addr[i]);
			check_value("mem_wdata of store", log_data[i], exp_data[i]);
		end
		if (log_addr.size() > exp_addr.size()) begin
			other_errors++;
			$display("%s: %0d stores happened that should not have, the first at address 0x%h",
				test_name, log_addr.size() - common, log_addr[common]);
		end else if (log_addr.size() < exp_addr.size()) begin
			other_errors++;
			$display("%s: %0d expected stores never happened, the first to address 0x%h",
				test_name, exp_addr.size() - common, exp_addr[common]);
		end
	endtask

	task test_arith();
		$display("running arithmetic and forwarding test");
		clear_memories();
		emit(imm_form(opc_add, 1, 0, 7));
		emit(imm_form(opc_add, 2, 1, -3));
		emit(ldst_word(opc_str, 2, 0, 1));
		emit(reg_form(opc_add, 3, 1, 2));
		emit(reg_form(opc_and, 4, 3, 1));
		emit(imm_form(opc_and, 5, 3, -2));
		emit(not_word(6, 5));
		emit(ldst_word(opc_str, 6, 0, 5));
		emit(lea_word(7, 4));
		emit(ldst_word(opc_str, 1, 7, 1));
		emit(ldst_word(opc_str, 7, 0, 6));
		emit(ldst_word(opc_str, 3, 0, 2));
		emit(ldst_word(opc_str, 4, 0, 3));
		emit(ldst_word(opc_str, 5, 0, 4));
		emit(branch_word(3'b111, -1));
		// R1=7 R2=4 R3=11 R4=11&7 R5=11&~1 R6=~R5 R7=16+2+8
		expect_store(16'h0002, 16'h0004);
		expect_store(16'h000a, 16'hfff5);
		expect_store(16'h001c, 16'h0007);
		expect_store(16'h000c, 16'h001a);
		expect_store(16'h0004, 16'h000b);
		expect_store(16'h0006, 16'h0003);
		expect_store(16'h0008, 16'h000a);
		run_program();
		compare_store_log("arithmetic test");
	endtask

	task build_load_use();
		emit(ldst_word(opc_ldr, 1, 0, 8));
		emit(imm_form(opc_add, 2, 1, 5));
		emit(ldst_word(opc_str, 2, 0, 9));
		emit(ldst_word(opc_ldr, 3, 0, 10));
		emit(reg_form(opc_add, 4, 3, 1));
		emit(ldst_word(opc_str, 4, 0, 11));
		emit(ldst_word(opc_ldr, 5, 0, 9));
		emit(ldst_word(opc_str, 5, 0, 12));
		emit(branch_word(3'b111, -1));
		expect_store(16'h0012, data_fill(8) + 16'd5);
		expect_store(16'h0016, data_fill(8) + data_fill(10));
		// reloads the word stored four instructions earlier
		expect_store(16'h0018, data_fill(8) + 16'd5);
	endtask

	task test_load_use();
		$display("running load-use test");
		clear_memories();
		build_load_use();
		run_program();
		compare_store_log("load-use test");
	endtask

	task test_branches();
		$display("running branch and jump test");
		clear_memories();
		emit(imm_form(opc_add, 1, 0, 1));
		emit(branch_word(3'b100, 3));
		emit(ldst_word(opc_str, 1, 0, 0));
		emit(branch_word(3'b001, 3));
		emit_skipped_stores(1, 1);
		emit(imm_form(opc_add, 2, 0, -1));
		emit(branch_word(3'b011, 1));
		emit(branch_word(3'b100, 3));
		emit_skipped_stores(2, 4);
		emit(ldst_word(opc_str, 2, 0, 7));
		emit(imm_form(opc_and, 3, 1, 0));
		emit(branch_word(3'b101, 1));
		emit(branch_word(3'b010, 3));
		emit_skipped_stores(1, 8);
		// jump target is pc 52
		emit(lea_word(4, 5));
		emit(jump_word(4));
		emit_skipped_stores(4, 11);
		emit(ldst_word(opc_str, 1, 0, 14));
		emit(ldst_word(opc_str, 4, 0, 15));
		emit(branch_word(3'b111, -1));
		expect_store(16'h0000, 16'h0001);
		expect_store(16'h000e, 16'hffff);
		expect_store(16'h001e, 16'h0034);
		run_program();
		compare_store_log("branch test");
	endtask

	task test_mem_wait();
		logic [15:0] ref_addr [$];
		logic [15:0] ref_data [$];
		$display("running memory wait test");
		random_delay = 1'b0;
		clear_memories();
		build_load_use();
		run_program();
		compare_store_log("zero-delay run");
		ref_addr = log_addr;
		ref_data = log_data;
		random_delay = 1'b1;
		clear_memories();
		build_load_use();
		exp_addr = ref_addr;
		exp_data = ref_data;
		run_program();
		compare_store_log("random-delay run");
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles) begin
			@(posedge clk);
			cycle_count++;
		end
		other_errors++;
		$display("timeout: the core did not settle in its final loop within %0d cycles",
			timeout_cycles);
		$display("checks %0d, value errors %0d, other errors %0d",
			checks, value_errors, other_errors);
		$display("Regression failed");
		$finish;
	end

	initial begin
		rst = 1'b1;
		mem_rdata = 16'h0000;
		mem_resp = 1'b0;
		busy = 1'b0;
		wait_left = 0;
		random_delay = 1'b1;
		lfsr_state = 16'd98;
		checks = 0;
		value_errors = 0;
		other_errors = 0;
		test_arith();
		test_load_use();
		test_branches();
		test_mem_wait();
		$display("checks %0d, value errors %0d, other errors %0d",
			checks, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+.
lc3b_pkg.sv
lc3b_decode.sv
lc3b_regfile.sv
lc3b_fetch.sv
lc3b_hazard.sv
lc3b_execute.sv
lc3b_memstage.sv
lc3b_core.sv
tb_lc3b.sv

// File: Bender.yml
package:
  name: lc3b_core

export_include_dirs:
  - .

sources:
  - files:
      - lc3b_pkg.sv
      - lc3b_decode.sv
      - lc3b_regfile.sv
      - lc3b_fetch.sv
      - lc3b_hazard.sv
      - lc3b_execute.sv
      - lc3b_memstage.sv
      - lc3b_core.sv
  - target: test
    files:
      - tb_lc3b.sv
